// File: project.f
+incdir+include
rtl/core_pkg.sv
rtl/regfile.sv
rtl/decoder.sv
rtl/exec_stage.sv
rtl/core_top.sv
tests/tb_core_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and looks for the pass message in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tb_core_top -o sim_core
./obj_dir/sim_core | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: include/rv_encode.svh
// instruction encoders for the testbench, covering the subset the core runs
// include inside the testbench module and build program words from these helpers
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_STORE  = 7'b0100011;

localparam logic [2:0] F3_ADD = 3'b000;
localparam logic [2:0] F3_SLL = 3'b001;
localparam logic [2:0] F3_SLT = 3'b010;
localparam logic [2:0] F3_XOR = 3'b100;
localparam logic [2:0] F3_SRL = 3'b101;
localparam logic [2:0] F3_OR  = 3'b110;
localparam logic [2:0] F3_AND = 3'b111;
localparam logic [2:0] F3_SW  = 3'b010;

localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_SUB  = 7'b0100000;

// register-register, SUB uses F7_SUB with F3_ADD
function automatic logic [31:0] enc_r(logic [6:0] funct7, logic [4:0] rs2,
	logic [4:0] rs1, logic [2:0] funct3, logic [4:0] rd);
	return {funct7, rs2, rs1, funct3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
	logic [2:0] funct3, logic [4:0] rd);
	return {imm, rs1, funct3, rd, OPC_OP_IMM};
endfunction

// S-type offset split around rs2 and rs1
function automatic logic [31:0] enc_sw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_lui(logic [19:0] imm, logic [4:0] rd);
	return {imm, rd, OPC_LUI};
endfunction

`endif

// File: tests/tb_core_top.sv
// testbench for the pipeline core, runs a random program against a reference model
// stores are compared in order while instruction gaps and store back-pressure vary
`timescale 1ns/1ps

module tb_core_top import core_pkg::*; ();

	`include "rv_encode.svh"

	localparam int NUM_INST = 400;
	localparam int WATCHDOG_CYCLES = 4 * NUM_INST + 100;
	localparam logic [31:0] SEED = 32'hdd52af16;
	// funct3 values the core executes, indexed by funct3
	localparam logic [7:0] R_OK = 8'b1111_0111;
	localparam logic [7:0] I_OK = 8'b1101_0101;

	logic       clk_i = 1'b0;
	logic       reset_i;
	logic       inst_valid_i;
	inst_t      inst_i;
	logic       inst_ready_o;
	logic       store_valid_o;
	store_req_t store_o;
	logic       store_ready_i;

	logic [31:0] rng_state = SEED;
	logic [31:0] bp_state = SEED;
	word_t       model_rf [32];
	store_req_t  exp_q [$];
	inst_t       prog [$];
	int          exp_total = 0;
	int          rcvd = 0;
	int          err_value = 0;
	int          err_other = 0;
	int          err_count = 0;
	logic        stalled_q = 1'b0;
	logic        reset_q = 1'b1;
	store_req_t  stalled_store;

	core_top i_core_top (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.inst_valid_i  (inst_valid_i),
		.inst_i        (inst_i),
		.inst_ready_o  (inst_ready_o),
		.store_valid_o (store_valid_o),
		.store_o       (store_o),
		.store_ready_i (store_ready_i)
	);

	always #50 clk_i = ~clk_i;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = lcg_next(rng_state);
		return rng_state;
	endfunction

	// x0..x7 only, so dependencies between neighbours are frequent
	function automatic reg_addr_t pick_reg();
		logic [31:0] r;
		r = rand_word();
		return {2'b00, r[30:28]};
	endfunction

	function automatic void build_program();
		logic [31:0] w;
		logic [6:0]  f7;
		logic [2:0]  f3;
		for (int r = 1; r < 8; r++) begin
			w = rand_word();
			prog.push_back(enc_lui(w[31:12], reg_addr_t'(r)));
			prog.push_back(enc_i(w[27:16], reg_addr_t'(r), F3_ADD, reg_addr_t'(r)));
		end
		while (prog.size() < NUM_INST) begin
			w = rand_word();
			if (w[31:28] < 4'd6) begin
				// funct3 011 stands in for SUB
				f7 = (w[27:25] == 3'd3) ? F7_SUB : F7_BASE;
				f3 = (w[27:25] == 3'd3) ? F3_ADD : w[27:25];
				prog.push_back(enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg()));
			end else if (w[31:28] < 4'd9) begin
				f3 = I_OK[w[26:24]] ? w[26:24] : F3_ADD;
				prog.push_back(enc_i(w[11:0], pick_reg(), f3, pick_reg()));
			end else if (w[31:28] == 4'd9) begin
				prog.push_back(enc_lui(w[19:0], pick_reg()));
			end else if (w[31:28] < 4'd14) begin
				prog.push_back(enc_sw(w[11:0], pick_reg(), pick_reg()));
			end else begin
				// load and system opcodes retire as no-ops
				prog.push_back({w[24:0], w[27] ? 7'b1110011 : 7'b0000011});
			end
		end
	endfunction

	// ISA result of one ALU operation, sub turns ADD into SUB
	function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
		case (f3)
			F3_ADD:  return sub ? a - b : a + b;
			F3_SLL:  return a << b[4:0];
			F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_XOR:  return a ^ b;
			F3_SRL:  return a >> b[4:0];
			F3_OR:   return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes one instruction on the model registers in program order
	function automatic void ref_exec(inst_t w);
		word_t      a;
		word_t      b;
		word_t      res;
		logic       wr;
		logic [2:0] f3;
		store_req_t st;
		a = model_rf[w[19:15]];
		b = model_rf[w[24:20]];
		f3 = w[14:12];
		res = '0;
		wr = 1'b0;
		if (w[6:0] == OPC_OP && R_OK[f3] &&
			(w[31:25] == F7_BASE || (w[31:25] == F7_SUB && f3 == F3_ADD))) begin
			res = alu_ref(f3, w[30], a, b);
			wr = 1'b1;
		end else if (w[6:0] == OPC_OP_IMM && I_OK[f3]) begin
			res = alu_ref(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
			wr = 1'b1;
		end else if (w[6:0] == OPC_LUI) begin
			res = {w[31:12], 12'h000};
			wr = 1'b1;
		end else if (w[6:0] == OPC_STORE && f3 == F3_SW) begin
			st.addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
			st.data = b;
			exp_q.push_back(st);
		end
		if (wr && w[11:7] != 5'd0) begin
			model_rf[w[11:7]] = res;
		end
	endfunction

	task automatic check_store(store_req_t got, store_req_t exp);
		if (got !== exp) begin
			$display("[FAIL] store_o got addr %h data %h, expected addr %h data %h",
				got.addr, got.data, exp.addr, exp.data);
			err_value++;
		end
	endtask

	task automatic check_store_count(int got, int exp);
		if (got != exp) begin
			$display("[FAIL] store count got %h expected %h", got, exp);
			err_count++;
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			err_value++;
		end
	endtask

	// monitor, samples at the falling edge where all outputs are settled
	always @(negedge clk_i) begin
		if (reset_i) begin
			check_flag("store_valid_o", store_valid_o, 1'b0);
		end else begin
			if (reset_q) begin
				check_flag("inst_ready_o", inst_ready_o, 1'b1);
				check_flag("store_valid_o", store_valid_o, 1'b0);
			end
			if (stalled_q) begin
				check_flag("store_valid_o", store_valid_o, 1'b1);
				check_store(store_o, stalled_store);
			end
			if (store_valid_o && store_ready_i) begin
				if (rcvd < exp_total) begin
					check_store(store_o, exp_q[rcvd]);
				end else begin
					$display("an extra store arrived with addr %h", store_o.addr);
					err_other++;
				end
				rcvd++;
			end
			stalled_q = store_valid_o && !store_ready_i;
			stalled_store = store_o;
		end
		reset_q = reset_i;
	end

	// store back-pressure, low about one cycle in four once reset is over
	initial begin
		store_ready_i = 1'b1;
		@(negedge reset_i);
		forever begin
			@(posedge clk_i);
			bp_state = lcg_next(bp_state);
			#1 store_ready_i = (bp_state[31:30] != 2'b00);
		end
	end

	initial begin
		logic        accepted;
		logic [31:0] gap;
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		for (int r = 0; r < 32; r++) begin
			model_rf[r] = '0;
		end
		build_program();
		foreach (prog[i]) begin
			ref_exec(prog[i]);
		end
		exp_total = exp_q.size();
		repeat (5) begin
			@(posedge clk_i);
			#1;
		end
		reset_i = 1'b0;
		foreach (prog[i]) begin
			gap = rand_word();
			if (gap[31:30] == 2'b00) begin
				repeat (gap[29] ? 2 : 1) begin
					@(posedge clk_i);
					#1;
				end
			end
			inst_valid_i = 1'b1;
			inst_i = prog[i];
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clk_i);
				accepted = inst_ready_o;
				@(posedge clk_i);
				#1;
			end
			inst_valid_i = 1'b0;
		end
		while (rcvd < exp_total) begin
			@(posedge clk_i);
		end
		// a few more cycles so a stray store would still be seen
		repeat (5) @(posedge clk_i);
		check_store_count(rcvd, exp_total);
		$display("errors: %0d value, %0d count, %0d other", err_value, err_count, err_other);
		if (err_value + err_count + err_other == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("timeout, the program did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: rtl/core_top.sv
// top level of the pipeline core
// instructions come in on a valid/ready stream, stores leave on another
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       inst_valid_i,
	input  inst_t      inst_i,
	output logic       inst_ready_o,
	output logic       store_valid_o,
	output store_req_t store_o,
	input  logic       store_ready_i
);

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;
	wb_t       ex_fwd;
	wb_t       wb;
	uop_t      uop;
	logic      uop_valid;
	logic      hold;

	decoder decoder0 (
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.hold_i       (hold),
		.inst_ready_o (inst_ready_o),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_fwd_i     (ex_fwd),
		.wb_fwd_i     (wb),
		.uop_o        (uop),
		.uop_valid_o  (uop_valid)
	);

	exec_stage exec_stage0 (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.uop_i         (uop),
		.uop_valid_i   (uop_valid),
		.hold_o        (hold),
		.ex_fwd_o      (ex_fwd),
		.wb_o          (wb),
		.store_valid_o (store_valid_o),
		.store_o       (store_o),
		.store_ready_i (store_ready_i)
	);

	// write port driven by the write-back register
	regfile regfile0 (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.wb_i       (wb),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

endmodule

// File: rtl/exec_stage.sv
// execute and write-back registers with the ALU
// a store waiting on the store stream holds the execute register and stalls decode
`timescale 1ns/1ps

module exec_stage import core_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  uop_t       uop_i,
	input  logic       uop_valid_i,
	output logic       hold_o,
	output wb_t        ex_fwd_o,
	output wb_t        wb_o,
	output logic       store_valid_o,
	output store_req_t store_o,
	input  logic       store_ready_i
);

	uop_t  ex_uop_q;
	logic  ex_valid_q;
	wb_t   wb_q;
	word_t alu_res;

	assign store_valid_o = ex_valid_q && ex_uop_q.is_store;
	assign hold_o        = store_valid_o && !store_ready_i;

	// execute register
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ex_valid_q <= 1'b0;
		end else if (!hold_o) begin
			ex_valid_q <= uop_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!hold_o) begin
			ex_uop_q <= uop_i;
		end
	end

	always_comb begin
		case (ex_uop_q.alu_op)
			ALU_ADD:    alu_res = ex_uop_q.op_a + ex_uop_q.op_b;
			ALU_SUB:    alu_res = ex_uop_q.op_a - ex_uop_q.op_b;
			ALU_AND:    alu_res = ex_uop_q.op_a & ex_uop_q.op_b;
			ALU_OR:     alu_res = ex_uop_q.op_a | ex_uop_q.op_b;
			ALU_XOR:    alu_res = ex_uop_q.op_a ^ ex_uop_q.op_b;
			ALU_SLT: begin
				alu_res = {31'b0, $signed(ex_uop_q.op_a) < $signed(ex_uop_q.op_b)};
			end
			ALU_SLL:    alu_res = ex_uop_q.op_a << ex_uop_q.op_b[4:0];
			ALU_SRL:    alu_res = ex_uop_q.op_a >> ex_uop_q.op_b[4:0];
			ALU_PASS_B: alu_res = ex_uop_q.op_b;
			default:    alu_res = '0;
		endcase
	end

	// result of the instruction now in execute, gated by its valid
	assign ex_fwd_o.we   = ex_valid_q && ex_uop_q.rd_we;
	assign ex_fwd_o.addr = ex_uop_q.rd;
	assign ex_fwd_o.data = alu_res;

	// SW address is op_a + op_b from the ALU
	assign store_o.addr = alu_res;
	assign store_o.data = ex_uop_q.store_data;

	// write-back register, takes an empty slot while the store is held
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_q.we <= 1'b0;
		end else if (hold_o) begin
			wb_q.we <= 1'b0;
		end else begin
			wb_q <= ex_fwd_o;
		end
	end

	assign wb_o = wb_q;

	// a stalled store stays presented and unchanged
	a_store_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		(store_valid_o && !store_ready_i) |=> (store_valid_o && $stable(store_o)));

	// decode presents no new uop while a store is held
	a_hold_store: assert property (@(posedge clk_i) disable iff (reset_i)
		hold_o |-> !uop_valid_i);

endmodule

// File: rtl/decoder.sv
// decode stage, purely combinational
// splits the instruction, resolves operands through forwarding and builds the uop
`timescale 1ns/1ps

module decoder import core_pkg::*; (
	input  logic      inst_valid_i,
	input  inst_t     inst_i,
	input  logic      hold_i,
	output logic      inst_ready_o,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,
	input  wb_t       ex_fwd_i,
	input  wb_t       wb_fwd_i,
	output uop_t      uop_o,
	output logic      uop_valid_o
);

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;
	word_t      rs1_val;
	word_t      rs2_val;

	assign opcode     = inst_i[6:0];
	assign rd         = inst_i[11:7];
	assign funct3     = inst_i[14:12];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];
	assign funct7     = inst_i[31:25];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_u = {inst_i[31:12], 12'b0};

	// execute result wins over write-back, write-back over the register file
	function automatic word_t fwd_sel(reg_addr_t addr, word_t rf_data, wb_t ex_fwd,
		wb_t wb_fwd);
		word_t val;
		if (addr == '0) begin
			val = '0;
		end else if (ex_fwd.we && ex_fwd.addr == addr) begin
			val = ex_fwd.data;
		end else if (wb_fwd.we && wb_fwd.addr == addr) begin
			val = wb_fwd.data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign rs1_val = fwd_sel(rs1_addr_o, rs1_data_i, ex_fwd_i, wb_fwd_i);
	assign rs2_val = fwd_sel(rs2_addr_o, rs2_data_i, ex_fwd_i, wb_fwd_i);

	// stream handshake
	assign inst_ready_o = !hold_i;
	assign uop_valid_o  = inst_valid_i && !hold_i;

	always_comb begin
		uop_o            = '0;
		uop_o.alu_op     = ALU_ADD;
		uop_o.op_a       = rs1_val;
		uop_o.op_b       = rs2_val;
		uop_o.store_data = rs2_val;
		uop_o.rd         = rd;
		case (opcode)
			OPC_OP: begin
				uop_o.rd_we = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: uop_o.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: uop_o.alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: uop_o.alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: uop_o.alu_op = ALU_SLT;
					{7'b0000000, 3'b100}: uop_o.alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: uop_o.alu_op = ALU_SRL;
					{7'b0000000, 3'b110}: uop_o.alu_op = ALU_OR;
					{7'b0000000, 3'b111}: uop_o.alu_op = ALU_AND;
					default: uop_o.rd_we = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				uop_o.op_b  = imm_i;
				uop_o.rd_we = 1'b1;
				case (funct3)
					3'b000: uop_o.alu_op = ALU_ADD;
					3'b010: uop_o.alu_op = ALU_SLT;
					3'b100: uop_o.alu_op = ALU_XOR;
					3'b110: uop_o.alu_op = ALU_OR;
					3'b111: uop_o.alu_op = ALU_AND;
					default: uop_o.rd_we = 1'b0;
				endcase
			end
			OPC_LUI: begin
				uop_o.alu_op = ALU_PASS_B;
				uop_o.op_b   = imm_u;
				uop_o.rd_we  = 1'b1;
			end
			OPC_STORE: begin
				// only SW, other widths retire as no-ops
				if (funct3 == 3'b010) begin
					uop_o.op_b     = imm_s;
					uop_o.is_store = 1'b1;
				end
			end
			default: begin
				uop_o.rd_we = 1'b0;
			end
		endcase
		// x0 target dropped here so it never shows up on a forwarding path
		if (rd == '0) begin
			uop_o.rd_we = 1'b0;
		end
	end

endmodule

// File: rtl/regfile.sv
// integer register file, two combinational read ports and one write port
// x0 reads as zero, a write in flight is visible on the read ports at once
`timescale 1ns/1ps

module regfile import core_pkg::*; (
	input  logic      clk_i,
	input  logic      reset_i,
	input  wb_t       wb_i,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o
);

	word_t regs [32];

	// entry 0 only ever sees the reset value
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.addr != '0) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// write-through so decode sees the value being written this cycle
	assign rs1_data_o = (wb_i.we && wb_i.addr != '0 && wb_i.addr == rs1_addr_i) ?
		wb_i.data : regs[rs1_addr_i];
	assign rs2_data_o = (wb_i.we && wb_i.addr != '0 && wb_i.addr == rs2_addr_i) ?
		wb_i.data : regs[rs2_addr_i];

	// x0 reads as zero on both ports, through storage and write-through alike
	a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
		(rs1_addr_i != '0 || rs1_data_o == '0) &&
		(rs2_addr_i != '0 || rs2_data_o == '0));

endmodule

// File: rtl/core_pkg.sv
// shared types for the three-stage RV32I integer pipeline
// every RTL module takes what it needs through a wildcard import in its header
package core_pkg;

	// data word, register index and raw instruction
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] inst_t;

	// alu operations
	// pass-b forwards op_b unchanged, used by LUI
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	// decoded operation, operands already resolved
	typedef struct packed {
		alu_op_e   alu_op;
		word_t     op_a;
		word_t     op_b;
		word_t     store_data;
		reg_addr_t rd;
		logic      rd_we;
		logic      is_store;
	} uop_t;

	// one register write, also used for forwarding
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	// store leaving the core
	typedef struct packed {
		word_t addr;
		word_t data;
	} store_req_t;

endpackage
